/* filelist.f */
hdl/exec_pkg.sv
hdl/issue_queue.sv
hdl/int_regfile.sv
hdl/int_alu.sv
hdl/ibr.sv
hdl/exec_cluster.sv
tests/tb_exec_cluster.sv

/* hdl/exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    input  exec_pkg::t_uop                disp_uop,
    input  exec_pkg::t_alu_op             disp_alu_op,
    input  exec_pkg::t_funct3             disp_funct3,
    input  exec_pkg::t_reg_idx            disp_rd,
    input  exec_pkg::t_reg_idx            disp_rs1,
    input  exec_pkg::t_reg_idx            disp_rs2,
    input  exec_pkg::t_rv_reg_data        disp_imm,
    input  exec_pkg::t_paddr              disp_pc,
    output logic [$clog2(IQ_DEPTH+1)-1:0] credit_ret,
    output logic                          wb_valid,
    output exec_pkg::t_reg_idx            wb_rd,
    output exec_pkg::t_rv_reg_data        wb_data,
    output logic                          redirect_valid,
    output exec_pkg::t_paddr              redirect_pc
);
    import exec_pkg::*;

    logic         iss_valid;
    t_uop         iss_uop;
    t_alu_op      iss_alu_op;
    t_funct3      iss_funct3;
    t_reg_idx     iss_rd;
    t_reg_idx     iss_rs1;
    t_reg_idx     iss_rs2;
    t_rv_reg_data iss_imm;
    t_paddr       iss_pc;

    // EX0 stage register
    logic         valid_ex0;
    t_uop         uop_ex0;
    t_alu_op      alu_op_ex0;
    t_funct3      funct3_ex0;
    t_reg_idx     rd_ex0;
    t_reg_idx     rs1_ex0;
    t_reg_idx     rs2_ex0;
    t_rv_reg_data imm_ex0;
    t_paddr       pc_ex0;

    t_rv_reg_data src1val_ex0;
    t_rv_reg_data src2val_ex0;
    t_rv_reg_data alu_src2_ex0;
    t_rv_reg_data alu_result_ex0;
    logic         alu_wb_ex0;
    logic         resvld_ex0;
    logic         br_mispred_ex0;
    t_paddr       br_tgt_ex0;

    issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
        .clk, .reset, .disp_valid, .disp_uop, .disp_alu_op, .disp_funct3,
        .disp_rd, .disp_rs1, .disp_rs2, .disp_imm, .disp_pc,
        .flush(br_mispred_ex0),
        .iss_valid, .iss_uop, .iss_alu_op, .iss_funct3, .iss_rd, .iss_rs1,
        .iss_rs2, .iss_imm, .iss_pc, .credit_ret
    );

    always_ff @(posedge clk) begin
        if (reset) valid_ex0 <= 1'b0;
        else valid_ex0 <= iss_valid;
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            uop_ex0    <= iss_uop;
            alu_op_ex0 <= iss_alu_op;
            funct3_ex0 <= iss_funct3;
            rd_ex0     <= iss_rd;
            rs1_ex0    <= iss_rs1;
            rs2_ex0    <= iss_rs2;
            imm_ex0    <= iss_imm;
            pc_ex0     <= iss_pc;
        end
    end

    // Written from EX1, bypassed back into EX0 reads
    int_regfile u_rf (
        .clk, .reset, .rs1(rs1_ex0), .rs2(rs2_ex0),
        .wr_en(wb_valid), .wr_idx(wb_rd), .wr_data(wb_data),
        .rs1_data(src1val_ex0), .rs2_data(src2val_ex0)
    );

    assign alu_src2_ex0 = (uop_ex0 == U_ALUI) ? imm_ex0 : src2val_ex0;

    int_alu u_alu (.alu_op(alu_op_ex0), .src1(src1val_ex0), .src2(alu_src2_ex0),
                   .result(alu_result_ex0));

    ibr u_ibr (
        .valid_ex0, .uop_ex0, .funct3_ex0, .pc_ex0, .imm_ex0, .src1val_ex0, .src2val_ex0,
        .resvld_ex0, .br_tgt_ex0, .br_mispred_ex0
    );

    // x0 destinations never reach writeback
    assign alu_wb_ex0 = valid_ex0 && ((uop_ex0 == U_ALU) || (uop_ex0 == U_ALUI)) &&
                        (rd_ex0 != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= alu_wb_ex0;
            redirect_valid <= br_mispred_ex0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_wb_ex0) begin
            wb_rd   <= rd_ex0;
            wb_data <= alu_result_ex0;
        end
        if (resvld_ex0) redirect_pc <= br_tgt_ex0; // Only meaningful with redirect_valid
    end

endmodule

`default_nettype wire

/* hdl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] t_rv_reg_data;
    typedef logic [63:0]     t_paddr;
    typedef logic [4:0]      t_reg_idx;
    typedef logic [2:0]      t_funct3;

    // Micro-op class, selects the execution unit in EX0
    typedef enum logic [1:0] {
        U_NOP  = 2'd0,
        U_ALU  = 2'd1, // rs1 op rs2
        U_ALUI = 2'd2, // rs1 op imm64
        U_BR   = 2'd3
    } t_uop;

    // Conditional branch encodings on funct3
    localparam t_funct3 RV_BR_BEQ  = 3'b000;
    localparam t_funct3 RV_BR_BNE  = 3'b001;
    localparam t_funct3 RV_BR_BLT  = 3'b100;
    localparam t_funct3 RV_BR_BGE  = 3'b101;
    localparam t_funct3 RV_BR_BLTU = 3'b110;
    localparam t_funct3 RV_BR_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,  // Signed compare
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9   // Sign fill
    } t_alu_op;

    // One queue entry, already decoded by the front end
    typedef struct packed {
        t_uop         uop;
        t_alu_op      alu_op;
        t_funct3      funct3;
        t_reg_idx     rd;
        t_reg_idx     rs1;
        t_reg_idx     rs2;
        t_rv_reg_data imm64;
        t_paddr       pc;
    } t_uinstr;

endpackage

`default_nettype wire

/* hdl/ibr.sv */
`timescale 1ns/1ps
`default_nettype none

module ibr (
    input  logic                   valid_ex0,
    input  exec_pkg::t_uop         uop_ex0,
    input  exec_pkg::t_funct3      funct3_ex0,
    input  exec_pkg::t_paddr       pc_ex0,
    input  exec_pkg::t_rv_reg_data imm_ex0,
    input  exec_pkg::t_rv_reg_data src1val_ex0,
    input  exec_pkg::t_rv_reg_data src2val_ex0,
    output logic                   resvld_ex0,
    output exec_pkg::t_paddr       br_tgt_ex0,
    output logic                   br_mispred_ex0
);
    import exec_pkg::*;

    t_paddr pcnxt_ex0;
    t_paddr tkn_tgt_ex0;
    t_paddr tru_tgt_ex0;
    logic   tkn_ex0;

    assign resvld_ex0 = valid_ex0 && (uop_ex0 == U_BR);

    assign pcnxt_ex0   = pc_ex0 + 64'd4;      // Predicted path
    assign tkn_tgt_ex0 = pc_ex0 + imm_ex0;

    // Condition evaluation, full 64-bit compares
    always_comb begin
        tkn_ex0 = 1'b0;
        case (funct3_ex0)
            RV_BR_BEQ:  tkn_ex0 = src1val_ex0 == src2val_ex0;
            RV_BR_BNE:  tkn_ex0 = src1val_ex0 != src2val_ex0;
            RV_BR_BLT:  tkn_ex0 = $signed(src1val_ex0) <  $signed(src2val_ex0);
            RV_BR_BGE:  tkn_ex0 = $signed(src1val_ex0) >= $signed(src2val_ex0);
            RV_BR_BLTU: tkn_ex0 = src1val_ex0 <  src2val_ex0;
            RV_BR_BGEU: tkn_ex0 = src1val_ex0 >= src2val_ex0;
            default:    tkn_ex0 = 1'b0;
        endcase
    end

    assign tru_tgt_ex0 = tkn_ex0 ? tkn_tgt_ex0 : pcnxt_ex0;

    // Not-taken prediction, so any other target is a mispredict
    assign br_mispred_ex0 = resvld_ex0 && (tru_tgt_ex0 != pcnxt_ex0);
    assign br_tgt_ex0     = tru_tgt_ex0;

endmodule

`default_nettype wire

/* hdl/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  exec_pkg::t_alu_op      alu_op,
    input  exec_pkg::t_rv_reg_data src1,
    input  exec_pkg::t_rv_reg_data src2,
    output exec_pkg::t_rv_reg_data result
);
    import exec_pkg::*;

    logic [5:0]   shamt;
    logic         lt_signed;
    logic         lt_unsigned;
    t_rv_reg_data sum;
    t_rv_reg_data diff;

    assign shamt = src2[5:0]; // RV64 shift amount

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        result = '0;
        case (alu_op)
            ADD: begin
                result = sum;
            end
            SUB: begin
                result = diff;
            end
            AND: begin
                result = src1 & src2;
            end
            OR: begin
                result = src1 | src2;
            end
            XOR: begin
                result = src1 ^ src2;
            end
            SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            SLL: begin
                result = src1 << shamt;
            end
            SRL: begin
                result = src1 >> shamt;
            end
            SRA: begin
                // Arithmetic shift keeps the sign of src1
                result = t_rv_reg_data'($signed(src1) >>> shamt);
            end
            default: begin
                result = '0; // Unused encodings
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/int_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  exec_pkg::t_reg_idx     rs1,
    input  exec_pkg::t_reg_idx     rs2,
    input  logic                   wr_en,
    input  exec_pkg::t_reg_idx     wr_idx,
    input  exec_pkg::t_rv_reg_data wr_data,
    output exec_pkg::t_rv_reg_data rs1_data,
    output exec_pkg::t_rv_reg_data rs2_data
);
    import exec_pkg::*;

    t_rv_reg_data regs [1:31]; // x0 has no storage

    // Same-cycle write wins over the stored value
    function automatic t_rv_reg_data read_port(input t_reg_idx idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && (wr_idx == idx)) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb rs1_data = read_port(rs1);
    always_comb rs2_data = read_port(rs2);

endmodule

`default_nettype wire

/* hdl/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    input  exec_pkg::t_uop                disp_uop,
    input  exec_pkg::t_alu_op             disp_alu_op,
    input  exec_pkg::t_funct3             disp_funct3,
    input  exec_pkg::t_reg_idx            disp_rd,
    input  exec_pkg::t_reg_idx            disp_rs1,
    input  exec_pkg::t_reg_idx            disp_rs2,
    input  exec_pkg::t_rv_reg_data        disp_imm,
    input  exec_pkg::t_paddr              disp_pc,
    input  logic                          flush,
    output logic                          iss_valid,
    output exec_pkg::t_uop                iss_uop,
    output exec_pkg::t_alu_op             iss_alu_op,
    output exec_pkg::t_funct3             iss_funct3,
    output exec_pkg::t_reg_idx            iss_rd,
    output exec_pkg::t_reg_idx            iss_rs1,
    output exec_pkg::t_reg_idx            iss_rs2,
    output exec_pkg::t_rv_reg_data        iss_imm,
    output exec_pkg::t_paddr              iss_pc,
    output logic [$clog2(IQ_DEPTH+1)-1:0] credit_ret
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(IQ_DEPTH + 1);
    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    t_uinstr          entries [IQ_DEPTH];
    t_uinstr          disp_entry;
    t_uinstr          head_entry;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] released;
    logic             push;

    // Wraps at IQ_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign disp_entry = '{uop: disp_uop, alu_op: disp_alu_op, funct3: disp_funct3,
                          rd: disp_rd, rs1: disp_rs1, rs2: disp_rs2,
                          imm64: disp_imm, pc: disp_pc};

    // Full queue drops the write, credits make that unreachable
    assign push      = disp_valid && !flush && (count != CNT_W'(IQ_DEPTH));
    assign iss_valid = (count != '0) && !flush;

    assign head_entry = entries[head];
    assign iss_uop    = head_entry.uop;
    assign iss_alu_op = head_entry.alu_op;
    assign iss_funct3 = head_entry.funct3;
    assign iss_rd     = head_entry.rd;
    assign iss_rs1    = head_entry.rs1;
    assign iss_rs2    = head_entry.rs2;
    assign iss_imm    = head_entry.imm64;
    assign iss_pc     = head_entry.pc;

    // Entries leaving this cycle, including a dispatch lost to the flush
    always_comb begin
        if (flush) begin
            released = count + CNT_W'(disp_valid);
        end else begin
            released = CNT_W'(iss_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            credit_ret <= '0;
        end else begin
            credit_ret <= released;
            if (flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (push) tail <= ptr_inc(tail);
                if (iss_valid) head <= ptr_inc(head);
                count <= count + CNT_W'(push) - CNT_W'(iss_valid);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) entries[tail] <= disp_entry;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_exec_cluster -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_exec_cluster > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "FAIL: see errors above" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" "$LOG" || { echo "No result in the log"; exit 1; }

echo "Simulation passed"
exit 0

/* tests/tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
    import exec_pkg::*;

    localparam int IQ_DEPTH   = 8;
    localparam int CNT_W      = $clog2(IQ_DEPTH + 1);
    localparam int NUM_UOPS   = 600;
    localparam int MAX_CYCLES = 5000;

    typedef struct packed {
        logic         is_redirect;
        t_reg_idx     rd;
        t_rv_reg_data value; // Write data or redirect target
    } t_expect;

    logic             clk = 1'b0;
    logic             reset;
    logic             disp_valid;
    t_uop             disp_uop;
    t_alu_op          disp_alu_op;
    t_funct3          disp_funct3;
    t_reg_idx         disp_rd;
    t_reg_idx         disp_rs1;
    t_reg_idx         disp_rs2;
    t_rv_reg_data     disp_imm;
    t_paddr           disp_pc;
    logic [CNT_W-1:0] credit_ret;
    logic             wb_valid;
    t_reg_idx         wb_rd;
    t_rv_reg_data     wb_data;
    logic             redirect_valid;
    t_paddr           redirect_pc;

    t_rv_reg_data arch_regs [32];
    t_expect      exp_q [$];         // Program order
    logic [31:0]  seed = 32'hbcbe;
    int           credits = IQ_DEPTH;
    int           value_errors = 0;
    int           other_errors = 0;
    logic         squash = 1'b0;     // Wrong path until the redirect
    t_paddr       fetch_pc = 64'h1000;
    t_paddr       resume_pc = '0;

    exec_cluster #(.IQ_DEPTH(IQ_DEPTH)) dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]}; // Better bits at the bottom
    endfunction

    // Mostly x0..x7 so that dependencies are frequent
    function automatic t_reg_idx pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[7:5] == 3'd0) return r[4:0];
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic signed_less(input t_rv_reg_data a, input t_rv_reg_data b);
        if (a[63] != b[63]) return a[63];
        return a < b;
    endfunction

    function automatic t_rv_reg_data expected_alu(input t_alu_op op, input t_rv_reg_data a,
                                                  input t_rv_reg_data b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 64'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return {63'd0, signed_less(a, b)};
            SLTU:    return {63'd0, a < b};
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[63] ? ~(~64'd0 >> sh) : 64'd0);
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input t_funct3 f, input t_rv_reg_data a,
                                          input t_rv_reg_data b);
        case (f)
            RV_BR_BEQ:  return a == b;
            RV_BR_BNE:  return a != b;
            RV_BR_BLT:  return signed_less(a, b);
            RV_BR_BGE:  return !signed_less(a, b);
            RV_BR_BLTU: return a < b;
            RV_BR_BGEU: return !(a < b);
            default:    return 1'b0;
        endcase
    endfunction

    task automatic check_outputs();
        t_expect e;
        assert (int'(credit_ret) <= IQ_DEPTH - credits) else begin
            $display("Credit return of %0d is more than the %0d credits outstanding",
                     credit_ret, IQ_DEPTH - credits);
            other_errors++;
        end
        credits += int'(credit_ret);
        if (wb_valid || redirect_valid) begin
            if (exp_q.size() == 0) begin
                $display("Result appeared while none was expected");
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                assert (redirect_valid == e.is_redirect && wb_valid != e.is_redirect) else begin
                    $display("Result kind differs from the next expected result");
                    other_errors++;
                end
                if (wb_valid && !e.is_redirect) begin
                    assert (wb_rd == e.rd) else begin
                        $display("FAILED wb_rd: got %h, expected %h", wb_rd, e.rd);
                        value_errors++;
                    end
                    assert (wb_data == e.value) else begin
                        $display("FAILED wb_data: got %h, expected %h", wb_data, e.value);
                        value_errors++;
                    end
                end
                if (redirect_valid && e.is_redirect) begin
                    assert (redirect_pc == e.value) else begin
                        $display("FAILED redirect_pc: got %h, expected %h", redirect_pc, e.value);
                        value_errors++;
                    end
                end
            end
        end
        if (redirect_valid && squash) begin
            squash   = 1'b0;
            fetch_pc = resume_pc; // Back on the correct path
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
        check_outputs();
    endtask

    task automatic dispatch_random();
        logic [31:0]  r;
        logic [31:0]  r2;
        t_rv_reg_data imm;
        t_rv_reg_data src1;
        t_rv_reg_data src2;
        t_rv_reg_data res;
        r   = next_rand();
        r2  = next_rand();
        imm = {{52{r2[11]}}, r2[11:0]};
        if (r2[20]) imm = {next_rand(), next_rand()};
        disp_valid  = 1'b1;
        disp_rd     = pick_reg();
        disp_rs1    = pick_reg();
        disp_rs2    = pick_reg();
        disp_alu_op = t_alu_op'(4'((r >> 4) % 10));
        disp_pc     = fetch_pc;
        case ((r >> 8) % 6)
            0:       disp_funct3 = RV_BR_BEQ;
            1:       disp_funct3 = RV_BR_BNE;
            2:       disp_funct3 = RV_BR_BLT;
            3:       disp_funct3 = RV_BR_BGE;
            4:       disp_funct3 = RV_BR_BLTU;
            default: disp_funct3 = RV_BR_BGEU;
        endcase
        if (r[3:0] == 4'd0) disp_uop = U_NOP;
        else if (r[3:0] < 4'd4) disp_uop = U_BR;
        else if (r[3:0] < 4'd10) disp_uop = U_ALU;
        else disp_uop = U_ALUI;
        if (disp_uop == U_BR) begin
            imm = {imm[61:0], 2'b00};
            if (imm == 64'd4) imm = 64'd8; // pc plus 4 is the predicted path
        end
        disp_imm = imm;
        fetch_pc = fetch_pc + 64'd4;
        credits--;
        if (!squash) begin
            src1 = arch_regs[disp_rs1];
            src2 = (disp_uop == U_ALUI) ? imm : arch_regs[disp_rs2];
            if (disp_uop == U_BR) begin
                if (branch_taken(disp_funct3, src1, src2)) begin
                    resume_pc = disp_pc + imm;
                    exp_q.push_back(t_expect'{is_redirect: 1'b1, rd: '0, value: resume_pc});
                    squash = 1'b1;
                end
            end else if (disp_uop != U_NOP && disp_rd != '0) begin
                res = expected_alu(disp_alu_op, src1, src2);
                arch_regs[disp_rd] = res;
                exp_q.push_back(t_expect'{is_redirect: 1'b0, rd: disp_rd, value: res});
            end
        end
    endtask

    initial begin
        int cycles;
        int dispatched;
        reset       = 1'b1;
        disp_valid  = 1'b0;
        disp_uop    = U_NOP;
        disp_alu_op = ADD;
        disp_funct3 = '0;
        disp_rd     = '0;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_imm    = '0;
        disp_pc     = '0;
        foreach (arch_regs[i]) arch_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Nothing dispatched yet
        repeat (6) begin
            step_cycle();
            assert (!wb_valid && !redirect_valid && credit_ret == '0) else begin
                $display("Output active after reset with no dispatch");
                other_errors++;
            end
        end

        dispatched = 0;
        cycles     = 0;
        while (dispatched < NUM_UOPS && cycles < MAX_CYCLES) begin
            step_cycle();
            cycles++;
            disp_valid = 1'b0;
            if (credits > 0 && next_rand() % 4 != 0) begin
                dispatch_random();
                dispatched++;
            end
        end
        if (dispatched < NUM_UOPS) begin
            $display("Timeout: only %0d of %0d micro-ops dispatched", dispatched, NUM_UOPS);
            other_errors++;
        end

        step_cycle(); // Last dispatch is sampled on this edge
        disp_valid = 1'b0;
        repeat (50) step_cycle(); // Drain and collect all credits
        assert (credits == IQ_DEPTH) else begin
            $display("FAILED credits: got %h, expected %h", credits, IQ_DEPTH);
            value_errors++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected results never appeared", exp_q.size());
            other_errors++;
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
